// ==== logic/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int PROD_W     = 2 * DATA_W;
    localparam int COUNT_W    = 6;  // Holds 0 to 32

    // Operation codes
    typedef enum logic [4:0] {
        OP_OR    = 5'd0,
        OP_AND   = 5'd1,
        OP_NOR   = 5'd2,
        OP_XOR   = 5'd3,
        OP_SLL   = 5'd4,
        OP_SRL   = 5'd5,
        OP_SRA   = 5'd6,
        OP_ADD   = 5'd7,
        OP_ADDU  = 5'd8,
        OP_ADDI  = 5'd9,
        OP_ADDIU = 5'd10,
        OP_SUB   = 5'd11,
        OP_SUBU  = 5'd12,
        OP_SLT   = 5'd13,
        OP_SLTU  = 5'd14,
        OP_CLZ   = 5'd15,
        OP_CLO   = 5'd16,
        OP_MULT  = 5'd17,
        OP_MULTU = 5'd18,
        OP_MUL   = 5'd19,
        OP_MFHI  = 5'd20,
        OP_MFLO  = 5'd21,
        OP_MTHI  = 5'd22,
        OP_MTLO  = 5'd23,
        OP_MADD  = 5'd24,
        OP_MADDU = 5'd25,
        OP_MSUB  = 5'd26,
        OP_MSUBU = 5'd27
    } ex_op_e;

    // Result class, derived from the operation code
    typedef enum logic [3:0] {
        CLS_LOGIC      = 4'd0,
        CLS_SHIFT      = 4'd1,
        CLS_ARITH      = 4'd2,
        CLS_MUL_LOW    = 4'd3,
        CLS_HILO_READ  = 4'd4,
        CLS_HILO_WRITE = 4'd5,
        CLS_MULT       = 4'd6,
        CLS_MULT_ACC   = 4'd7,
        CLS_MULT_SUB   = 4'd8
    } ex_class_e;

    typedef struct packed {
        ex_op_e                op;
        logic [DATA_W-1:0]     op1;
        logic [DATA_W-1:0]     op2;
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
    } ex_req_t;

    // Product for the multiply classes, plain result word for the rest
    typedef union packed {
        logic [PROD_W-1:0] prod;
        struct packed {
            logic [DATA_W-1:0] upper;  // Always zero
            logic [DATA_W-1:0] word;
        } res;
    } ex_payload_u;

    typedef struct packed {
        ex_class_e             cls;
        logic                  hi_sel;  // mfhi/mthi when set
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic [DATA_W-1:0]     op1;
        ex_payload_u           payload;
    } ex_item_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic [DATA_W-1:0]     wdata;
        logic                  whilo;
        logic [DATA_W-1:0]     hi;
        logic [DATA_W-1:0]     lo;
    } ex_wb_t;

endpackage

`default_nettype wire

// ==== logic/ex_lead_count.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_lead_count (
    input  logic [ex_pkg::DATA_W-1:0]  word_i,
    input  logic                       count_ones_i,
    output logic [ex_pkg::COUNT_W-1:0] count_o
);
    import ex_pkg::*;

    logic [DATA_W-1:0] scan;  // Word with leading ones turned to zeros

    assign scan = count_ones_i ? ~word_i : word_i;

    // Highest set bit wins since the loop runs upward
    always_comb begin
        count_o = COUNT_W'(DATA_W);
        for (int i = 0; i < DATA_W; i++) begin
            if (scan[i]) begin
                count_o = COUNT_W'(DATA_W - 1 - i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_issue (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             req_valid_i,
    input  ex_pkg::ex_req_t  req_i,
    output logic             req_ready_o,
    output logic             item_valid_o,
    output ex_pkg::ex_item_t item_o,
    input  logic             item_ready_i
);
    import ex_pkg::*;

    ex_class_e          cls;
    logic [SHAMT_W-1:0] shamt;
    logic [DATA_W-1:0]  logic_res;
    logic [DATA_W-1:0]  shift_res;
    logic [DATA_W-1:0]  arith_res;
    logic [DATA_W-1:0]  op2_mux;
    logic [DATA_W-1:0]  sum;
    logic [DATA_W-1:0]  word;
    logic               is_sub;
    logic               ov;
    logic               ov_check;
    logic [COUNT_W-1:0] lead_cnt;
    logic               signed_mul;
    logic [DATA_W-1:0]  mag1;
    logic [DATA_W-1:0]  mag2;
    logic [PROD_W-1:0]  prod_mag;
    logic [PROD_W-1:0]  product;
    ex_item_t           item_nxt;
    ex_item_t           item_q;
    logic               item_valid_q;
    logic               armed_q;  // Holds ready low until the first edge
    logic               accept;

    always_comb begin
        unique case (req_i.op)
            OP_OR, OP_AND, OP_NOR, OP_XOR: cls = CLS_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:        cls = CLS_SHIFT;
            OP_MUL:                        cls = CLS_MUL_LOW;
            OP_MFHI, OP_MFLO:              cls = CLS_HILO_READ;
            OP_MTHI, OP_MTLO:              cls = CLS_HILO_WRITE;
            OP_MULT, OP_MULTU:             cls = CLS_MULT;
            OP_MADD, OP_MADDU:             cls = CLS_MULT_ACC;
            OP_MSUB, OP_MSUBU:             cls = CLS_MULT_SUB;
            default:                       cls = CLS_ARITH;
        endcase
    end

    always_comb begin
        unique case (req_i.op)
            OP_OR:   logic_res = req_i.op1 | req_i.op2;
            OP_AND:  logic_res = req_i.op1 & req_i.op2;
            OP_NOR:  logic_res = ~(req_i.op1 | req_i.op2);
            OP_XOR:  logic_res = req_i.op1 ^ req_i.op2;
            default: logic_res = '0;
        endcase
    end

    assign shamt = req_i.op1[SHAMT_W-1:0];

    always_comb begin
        unique case (req_i.op)
            OP_SLL:  shift_res = req_i.op2 << shamt;
            OP_SRL:  shift_res = req_i.op2 >> shamt;
            OP_SRA:  shift_res = DATA_W'($signed(req_i.op2) >>> shamt);  // Sign fill
            default: shift_res = '0;
        endcase
    end

    // Subtraction as a + ~b + 1
    assign is_sub   = (req_i.op == OP_SUB) || (req_i.op == OP_SUBU);
    assign op2_mux  = is_sub ? ~req_i.op2 : req_i.op2;
    assign sum      = req_i.op1 + op2_mux + DATA_W'(is_sub);
    assign ov       = (req_i.op1[DATA_W-1] == op2_mux[DATA_W-1])
                   && (sum[DATA_W-1] != req_i.op1[DATA_W-1]);
    assign ov_check = (req_i.op == OP_ADD) || (req_i.op == OP_ADDI) || (req_i.op == OP_SUB);

    ex_lead_count u_lead_count (
        .word_i       (req_i.op1),
        .count_ones_i (req_i.op == OP_CLO),
        .count_o      (lead_cnt)
    );

    always_comb begin
        unique case (req_i.op)
            OP_SLT:         arith_res = DATA_W'($signed(req_i.op1) < $signed(req_i.op2));
            OP_SLTU:        arith_res = DATA_W'(req_i.op1 < req_i.op2);
            OP_CLZ, OP_CLO: arith_res = DATA_W'(lead_cnt);
            default:        arith_res = sum;
        endcase
    end

    // Multiply on magnitudes, re-sign afterwards
    assign signed_mul = (req_i.op == OP_MULT) || (req_i.op == OP_MUL)
                     || (req_i.op == OP_MADD) || (req_i.op == OP_MSUB);
    assign mag1       = (signed_mul && req_i.op1[DATA_W-1]) ? -req_i.op1 : req_i.op1;
    assign mag2       = (signed_mul && req_i.op2[DATA_W-1]) ? -req_i.op2 : req_i.op2;
    assign prod_mag   = PROD_W'(mag1) * PROD_W'(mag2);
    assign product    = (signed_mul && (req_i.op1[DATA_W-1] ^ req_i.op2[DATA_W-1]))
                        ? -prod_mag : prod_mag;

    always_comb begin
        unique case (cls)
            CLS_LOGIC: word = logic_res;
            CLS_SHIFT: word = shift_res;
            CLS_ARITH: word = arith_res;
            default:   word = '0;
        endcase
    end

    always_comb begin
        item_nxt.cls    = cls;
        item_nxt.hi_sel = (req_i.op == OP_MFHI) || (req_i.op == OP_MTHI);
        item_nxt.wd     = req_i.wd;
        item_nxt.wreg   = req_i.wreg && !(ov_check && ov);  // Drop write on overflow
        item_nxt.op1    = req_i.op1;
        if ((cls == CLS_MUL_LOW) || (cls == CLS_MULT) ||
            (cls == CLS_MULT_ACC) || (cls == CLS_MULT_SUB)) begin
            item_nxt.payload.prod = product;
        end else begin
            item_nxt.payload.res.upper = '0;
            item_nxt.payload.res.word  = word;
        end
    end

    assign req_ready_o = armed_q && (!item_valid_q || item_ready_i);
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            armed_q      <= 1'b0;
            item_valid_q <= 1'b0;
        end else begin
            armed_q <= 1'b1;
            if (accept) begin
                item_valid_q <= 1'b1;
            end else if (item_ready_i) begin
                item_valid_q <= 1'b0;  // Drained
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            item_q <= item_nxt;
        end
    end

    assign item_valid_o = item_valid_q;
    assign item_o       = item_q;

endmodule

`default_nettype wire

// ==== logic/ex_skid_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_skid_buffer (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             in_valid_i,
    input  ex_pkg::ex_item_t in_item_i,
    output logic             in_ready_o,
    output logic             out_valid_o,
    output ex_pkg::ex_item_t out_item_o,
    input  logic             out_ready_i
);
    import ex_pkg::*;

    ex_item_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count_q;
    logic [1:0] count_nxt;
    logic       ready_q;
    logic       push;
    logic       pop;

    assign push      = in_valid_i && ready_q;
    assign pop       = out_valid_o && out_ready_i;
    assign count_nxt = count_q + 2'(push) - 2'(pop);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count_q <= '0;
            ready_q <= 1'b0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop) rd_ptr <= !rd_ptr;
            count_q <= count_nxt;
            ready_q <= (count_nxt != 2'd2);  // Room for one more next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item_i;
        end
    end

    assign in_ready_o  = ready_q;
    assign out_valid_o = (count_q != '0);
    assign out_item_o  = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/ex_hilo_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_hilo_stage (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             item_valid_i,
    input  ex_pkg::ex_item_t item_i,
    output logic             item_ready_o,
    output logic             wb_valid_o,
    output ex_pkg::ex_wb_t   wb_o,
    input  logic             wb_ready_i
);
    import ex_pkg::*;

    logic [DATA_W-1:0] hi_q;
    logic [DATA_W-1:0] lo_q;
    logic [PROD_W-1:0] prod;
    logic [PROD_W-1:0] hilo_cur;
    logic [PROD_W-1:0] hilo_nxt;
    logic              whilo;
    logic [DATA_W-1:0] wdata;
    ex_wb_t            wb_nxt;
    ex_wb_t            wb_q;
    logic              wb_valid_q;
    logic              take;

    assign prod     = item_i.payload.prod;
    assign hilo_cur = {hi_q, lo_q};

    always_comb begin
        hilo_nxt = hilo_cur;
        whilo    = 1'b0;
        wdata    = '0;
        unique case (item_i.cls)
            CLS_LOGIC, CLS_SHIFT, CLS_ARITH: wdata = item_i.payload.res.word;
            CLS_MUL_LOW:   wdata = prod[DATA_W-1:0];
            CLS_HILO_READ: wdata = item_i.hi_sel ? hi_q : lo_q;
            CLS_HILO_WRITE: begin
                whilo = 1'b1;
                if (item_i.hi_sel) begin
                    hilo_nxt[PROD_W-1:DATA_W] = item_i.op1;
                end else begin
                    hilo_nxt[DATA_W-1:0] = item_i.op1;
                end
            end
            CLS_MULT: begin
                whilo    = 1'b1;
                hilo_nxt = prod;
            end
            CLS_MULT_ACC: begin
                whilo    = 1'b1;
                hilo_nxt = hilo_cur + prod;  // Wraps modulo 2^64
            end
            CLS_MULT_SUB: begin
                whilo    = 1'b1;
                hilo_nxt = hilo_cur - prod;
            end
            default: wdata = '0;
        endcase
    end

    always_comb begin
        wb_nxt.wd    = item_i.wd;
        wb_nxt.wreg  = item_i.wreg;
        wb_nxt.wdata = wdata;
        wb_nxt.whilo = whilo;
        wb_nxt.hi    = whilo ? hilo_nxt[PROD_W-1:DATA_W] : '0;
        wb_nxt.lo    = whilo ? hilo_nxt[DATA_W-1:0] : '0;
    end

    assign item_ready_o = !wb_valid_q || wb_ready_i;
    assign take         = item_valid_i && item_ready_o;

    // HI/LO change on the same edge the item is taken
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_q       <= '0;
            lo_q       <= '0;
            wb_q       <= '0;
            wb_valid_q <= 1'b0;
        end else if (take) begin
            {hi_q, lo_q} <= hilo_nxt;
            wb_q         <= wb_nxt;
            wb_valid_q   <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_q <= 1'b0;
            wb_q.whilo <= 1'b0;  // No HI/LO flag without a valid result
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_o       = wb_q;

endmodule

`default_nettype wire

// ==== logic/ex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            in_valid_i,
    input  ex_pkg::ex_req_t in_req_i,
    output logic            in_ready_o,
    output logic            out_valid_o,
    output ex_pkg::ex_wb_t  out_wb_o,
    input  logic            out_ready_i
);
    import ex_pkg::*;

    ex_item_t issue_item;   // Issue to buffer
    logic     issue_valid;
    logic     issue_ready;
    ex_item_t buf_item;     // Buffer to HI/LO stage
    logic     buf_valid;
    logic     buf_ready;

    ex_issue u_issue (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (in_valid_i),
        .req_i        (in_req_i),
        .req_ready_o  (in_ready_o),
        .item_valid_o (issue_valid),
        .item_o       (issue_item),
        .item_ready_i (issue_ready)
    );

    // Cuts the ready path back to the issue stage
    ex_skid_buffer u_skid_buffer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (issue_valid),
        .in_item_i   (issue_item),
        .in_ready_o  (issue_ready),
        .out_valid_o (buf_valid),
        .out_item_o  (buf_item),
        .out_ready_i (buf_ready)
    );

    ex_hilo_stage u_hilo_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .item_valid_i (buf_valid),
        .item_i       (buf_item),
        .item_ready_o (buf_ready),
        .wb_valid_o   (out_valid_o),
        .wb_o         (out_wb_o),
        .wb_ready_i   (out_ready_i)
    );

endmodule

`default_nettype wire

// ==== test/ex_tb_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_tb_asserts (
    input logic           clk,
    input logic           arst_n_i,
    input logic           valid_i,
    input ex_pkg::ex_wb_t wb_i,
    input logic           ready_i
);

    // Nothing offered while reset is held
    no_valid_in_reset: assert property (@(posedge clk) !arst_n_i |-> !valid_i)
        else $error("Result offered while reset was held");

    // A stalled result keeps its value until taken
    hold_while_stalled: assert property (@(posedge clk) disable iff (!arst_n_i)
        (valid_i && !ready_i) |=> (valid_i && $stable(wb_i)))
        else $error("Result changed or vanished while stalled");

    // HI/LO flag only travels with a valid result
    whilo_with_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_i.whilo |-> valid_i)
        else $error("HI/LO write flag high without a valid result");

endmodule

`default_nettype wire

// ==== test/ex_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_tb;
    import ex_pkg::*;

    localparam int FIELDS     = 11;   // Words per stimulus line
    localparam int MAX_LINES  = 64;
    localparam int WAIT_LIMIT = 200;  // Cycles allowed per wait loop
    localparam int BP_TEST    = 6;    // Back-pressure rerun reports as this test

    logic    clk;
    logic    arst_n_i;
    logic    in_valid_i;
    ex_req_t in_req_i;
    logic    in_ready_o;
    logic    out_valid_o;
    ex_wb_t  out_wb_o;
    logic    out_ready_i = 1'b1;

    logic [31:0] stim [FIELDS*MAX_LINES];
    ex_req_t     req_list [$];
    ex_wb_t      exp_list [$];
    int          test_list [$];
    logic [31:0] lfsr = 32'h194230a5;
    logic        backpressure = 1'b0;
    logic        aborted = 1'b0;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    ex_top dut0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_req_i    (in_req_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_wb_o    (out_wb_o),
        .out_ready_i (out_ready_i)
    );

    bind ex_top ex_tb_asserts u_asserts (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (out_valid_o),
        .wb_i     (out_wb_o),
        .ready_i  (out_ready_i)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = {1'b0, state[31:1]} ^ (state[0] ? 32'h80200003 : 32'h0);
    endfunction

    always @(posedge clk) begin
        if (backpressure) begin
            out_ready_i <= lfsr[0];  // One bit per step
            lfsr        <= lfsr_next(lfsr);
        end else begin
            out_ready_i <= 1'b1;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_stimulus();
        ex_req_t req;
        ex_wb_t  exp;
        int      base;
        $readmemh("test/ex_stimulus.txt", stim);
        for (int line = 0; line < MAX_LINES; line++) begin
            base = line * FIELDS;
            if ($isunknown(stim[base]) || stim[base] == 32'd0) begin
                break;  // Past the last line
            end
            req.op    = ex_op_e'(stim[base + 1][4:0]);
            req.op1   = stim[base + 2];
            req.op2   = stim[base + 3];
            req.wd    = stim[base + 4][REG_ADDR_W-1:0];
            req.wreg  = stim[base + 5][0];
            exp.wd    = stim[base + 4][REG_ADDR_W-1:0];
            exp.wdata = stim[base + 6];
            exp.wreg  = stim[base + 7][0];
            exp.whilo = stim[base + 8][0];
            exp.hi    = stim[base + 9];
            exp.lo    = stim[base + 10];
            req_list.push_back(req);
            exp_list.push_back(exp);
            test_list.push_back(int'(stim[base]));
        end
        if (req_list.size() == 0) begin
            $display("No requests could be read from test/ex_stimulus.txt");
            aborted = 1'b1;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n_i   <= 1'b0;
        in_valid_i <= 1'b0;
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
    endtask

    // Returns at the edge where the request is taken
    task automatic wait_for_accept(output logic ok);
        int waited;
        waited = 0;
        @(posedge clk);
        while (!in_ready_o && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        ok = in_ready_o;
    endtask

    task automatic wait_for_result(output logic ok);
        int waited;
        waited = 0;
        @(posedge clk);
        while (!(out_valid_o && out_ready_i) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        ok = out_valid_o && out_ready_i;
    endtask

    task automatic drive_requests();
        logic ok;
        for (int i = 0; i < req_list.size(); i++) begin
            in_valid_i <= 1'b1;
            in_req_i   <= req_list[i];
            wait_for_accept(ok);
            if (!ok) begin
                $display("Timeout: request %0d was never accepted", i);
                aborted = 1'b1;
                break;
            end
        end
        in_valid_i <= 1'b0;
    endtask

    task automatic compare_result(input int idx);
        ex_wb_t got;
        ex_wb_t exp;
        string  tag;
        got = out_wb_o;
        exp = exp_list[idx];
        tag = $sformatf("test %0d item %0d", test_list[idx], idx);
        check_value({tag, " wd"}, 32'(got.wd), 32'(exp.wd));
        check_value({tag, " wreg"}, 32'(got.wreg), 32'(exp.wreg));
        check_value({tag, " wdata"}, got.wdata, exp.wdata);
        check_value({tag, " whilo"}, 32'(got.whilo), 32'(exp.whilo));
        check_value({tag, " hi"}, got.hi, exp.hi);
        check_value({tag, " lo"}, got.lo, exp.lo);
    endtask

    task automatic report_test(input int id, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("Test %0d done: ok", id);
        end else begin
            tests_failed++;
            $display("Test %0d done: %0d mismatches", id, error_count - errors_before);
        end
    endtask

    // Results are matched strictly in request order
    task automatic collect_results(input logic as_one_test);
        logic ok;
        int   errors_before;
        errors_before = error_count;
        for (int i = 0; i < exp_list.size(); i++) begin
            wait_for_result(ok);
            if (!ok) begin
                $display("Timeout: result %0d never arrived", i);
                aborted = 1'b1;
                break;
            end
            compare_result(i);
            if (!as_one_test &&
                (i == exp_list.size() - 1 || test_list[i + 1] != test_list[i])) begin
                report_test(test_list[i], errors_before);
                errors_before = error_count;
            end
        end
        if (as_one_test && !aborted) begin
            report_test(BP_TEST, errors_before);
        end
    endtask

    task automatic run_pass(input logic use_backpressure);
        int extra;
        extra = 0;
        apply_reset();
        backpressure <= use_backpressure;
        fork
            drive_requests();
            collect_results(use_backpressure);
        join
        // Anything still offered now is a duplicate or stray result
        repeat (6) begin
            @(posedge clk);
            if (out_valid_o) extra++;
        end
        check_value("cycles with a stray result", 32'(extra), 32'd0);
    endtask

    initial begin
        arst_n_i   = 1'b0;
        in_valid_i = 1'b0;
        in_req_i   = '0;
        load_stimulus();
        if (!aborted) run_pass(1'b0);
        if (!aborted) run_pass(1'b1);
        $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0 && !aborted) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/ex_stimulus.txt ====
// test op op1 op2 wd wreg, then expected wdata wreg whilo hi lo (all hex)
// HI/LO is zero after reset and carries over from line to line
1 00 f0f01234 0f0f4321 01 1 ffff5335 1 0 00000000 00000000
1 01 f0f01234 0ff0ff00 07 1 00f01200 1 0 00000000 00000000
1 02 000000ff 0000ff00 02 1 ffff0000 1 0 00000000 00000000
1 03 a5a5a5a5 ffff0000 03 0 5a5aa5a5 0 0 00000000 00000000
1 04 00000024 12345678 04 1 23456780 1 0 00000000 00000000
1 05 00000004 87654321 05 1 08765432 1 0 00000000 00000000
1 06 00000008 80001234 06 1 ff800012 1 0 00000000 00000000
2 07 7fffffff 00000001 08 1 80000000 0 0 00000000 00000000
2 08 7fffffff 00000001 09 1 80000000 1 0 00000000 00000000
2 09 80000000 ffffffff 0a 1 7fffffff 0 0 00000000 00000000
2 0a 80000000 ffffffff 0b 1 7fffffff 1 0 00000000 00000000
2 0b 80000000 00000001 0c 1 7fffffff 0 0 00000000 00000000
2 0c 00000005 00000007 0d 1 fffffffe 1 0 00000000 00000000
2 0d ffffffff 00000001 0e 1 00000001 1 0 00000000 00000000
2 0e ffffffff 00000001 0f 1 00000000 1 0 00000000 00000000
3 0f 00000000 00000000 10 1 00000020 1 0 00000000 00000000
3 0f 00010000 00000000 11 1 0000000f 1 0 00000000 00000000
3 10 ffffffff 00000000 12 1 00000020 1 0 00000000 00000000
3 10 fff00000 00000000 13 1 0000000c 1 0 00000000 00000000
4 11 00000003 fffffffe 00 0 00000000 0 1 ffffffff fffffffa
4 14 00000000 00000000 14 1 ffffffff 1 0 00000000 00000000
4 15 00000000 00000000 15 1 fffffffa 1 0 00000000 00000000
4 12 ffffffff ffffffff 00 0 00000000 0 1 fffffffe 00000001
4 13 fffffffd 00000007 16 1 ffffffeb 1 0 00000000 00000000
4 14 00000000 00000000 17 1 fffffffe 1 0 00000000 00000000
4 16 12345678 00000000 00 0 00000000 0 1 12345678 00000001
4 17 9abcdef0 00000000 00 0 00000000 0 1 12345678 9abcdef0
4 15 00000000 00000000 18 1 9abcdef0 1 0 00000000 00000000
5 18 00000002 00000003 00 0 00000000 0 1 12345678 9abcdef6
5 18 ffffffff 00000010 00 0 00000000 0 1 12345678 9abcdee6
5 19 ffffffff 00000002 00 0 00000000 0 1 1234567a 9abcdee4
5 1a 00000004 fffffffe 00 0 00000000 0 1 1234567a 9abcdeec
5 1b 00000001 9abcdef0 00 0 00000000 0 1 12345679 fffffffc
5 16 00000000 00000000 00 0 00000000 0 1 00000000 fffffffc
5 17 00000000 00000000 00 0 00000000 0 1 00000000 00000000
5 1b 00000001 00000001 00 0 00000000 0 1 ffffffff ffffffff
5 19 00000001 00000001 00 0 00000000 0 1 00000000 00000000

// ==== project.f ====
logic/ex_pkg.sv
logic/ex_lead_count.sv
logic/ex_issue.sv
logic/ex_skid_buffer.sv
logic/ex_hilo_stage.sv
logic/ex_top.sv
test/ex_tb_asserts.sv
test/ex_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ex_tb \
    -f project.f -o ex_tb_sim || exit 1
sim_out="$(./obj_dir/ex_tb_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Testbench passed" && exit 0 || exit 1
